/* test/axi_sram_input.txt */
# op(1=write 0=read) addr wdata strb exp_rdata exp_resp stall order, all hex
# order 0 = AW first, 1 = W first, 2 = together; stall = ready low cycles
1 00000010 deadbeef f 00000000 0 0 0
0 00000010 00000000 0 deadbeef 0 0 0
1 00000010 000000aa 1 00000000 0 0 1
0 00000010 00000000 0 deadbeaa 0 0 0
1 00000010 55660000 c 00000000 0 0 2
0 00000010 00000000 0 5566beaa 0 0 0
1 00000020 11223344 f 00000000 0 0 1
1 00000024 a5a5a5a5 f 00000000 0 0 2
1 00000028 0f0f0f0f f 00000000 0 0 0
0 00000020 00000000 0 11223344 0 0 0
0 00000024 00000000 0 a5a5a5a5 0 0 0
0 00000028 00000000 0 0f0f0f0f 0 0 0
1 00000410 ffffffff f 00000000 2 0 0
0 00000410 00000000 0 00000000 2 0 0
0 00000010 00000000 0 5566beaa 0 0 0
1 000003fc 12345678 f 00000000 0 0 0
1 000003fc 9abcdef0 6 00000000 0 5 2
0 000003fc 00000000 0 12bcde78 0 7 0
1 80000000 cafef00d f 00000000 2 3 1
0 00000020 00000000 0 11223344 0 3 0

/* flist.f */
hw/axi_sram_pkg.sv
hw/axi_req_decode.sv
hw/sram_array_exec.sv
hw/axi_resp_result.sv
hw/axi_sram_top.sv
test/axi_sram_properties.sv
test/axi_sram_tb.sv

/* Bender.yml */
package:
  name: axi_sram

sources:
  - files:
      - hw/axi_sram_pkg.sv
      - hw/axi_req_decode.sv
      - hw/sram_array_exec.sv
      - hw/axi_resp_result.sv
      - hw/axi_sram_top.sv
  - target: test
    files:
      - test/axi_sram_properties.sv
      - test/axi_sram_tb.sv

/* test/axi_sram_tb.sv */
`timescale 1ns/1ps

module axi_sram_tb
  import axi_sram_pkg::*;
();

  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_resp;
    logic [7:0]  stall;
    logic [1:0]  order;
  } txn_t;

  logic                  aclk;
  logic                  areset;
  logic [addr_width-1:0] araddr;
  logic [addr_width-1:0] awaddr;
  logic [data_width-1:0] wdata;
  logic [data_width-1:0] rdata;
  logic [strb_width-1:0] wstrb;
  logic                  arvalid, arready, rvalid, rready;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  axi_resp_e             rresp;
  axi_resp_e             bresp;

  txn_t        txn_q[$];
  logic [31:0] shadow [mem_depth_words];
  int          seed = 32'h7d3f_6e67;
  int          cycle_count = 0;
  int          cycle_limit = 100;

  axi_sram_top u_axi_sram_top (.*);

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  // bound assertions count their own failures
  always @(negedge aclk) begin
    if (u_axi_sram_top.u_props.error_count != 0) begin
      $display("A bound AXI handshake assertion failed");
      $display("Test failures found");
      $fatal(1, "assertion failure");
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Test failures found");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    txn_t        t;
    logic [31:0] f [8];
    fd = $fopen("test/axi_sram_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file test/axi_sram_input.txt");
      $display("Test failures found");
      $fatal(1, "missing stimulus");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
          if (n == 8) begin
            t = {f[0][0], f[1], f[2], f[3][3:0], f[4], f[5][1:0], f[6][7:0], f[7][1:0]};
            txn_q.push_back(t);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) merged[8*i +: 8] = new_word[8*i +: 8];
    end
    return merged;
  endfunction

  // random idle cycles before a valid goes up
  task automatic valid_gap();
    int gap;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) @(posedge aclk);
  endtask

  // hold ready low for the stall count while the payload stays put
  task automatic take_b(input logic [7:0] stall, input logic [1:0] exp_resp);
    logic [1:0] held;
    do @(posedge aclk); while (!bvalid);
    held = bresp;
    repeat (stall) begin
      @(posedge aclk);
      check_value("bvalid", bvalid, 1'b1);
      check_value("bresp", bresp, held);
    end
    bready <= 1'b1;
    @(posedge aclk);
    check_value("bvalid", bvalid, 1'b1);
    bready <= 1'b0;
    check_value("bresp", held, exp_resp);
    // valid drops once the single B response is taken
    @(posedge aclk);
    check_value("bvalid", bvalid, 1'b0);
  endtask

  task automatic take_r(input logic [7:0] stall, input logic [31:0] exp_data,
                        input logic [1:0] exp_resp);
    logic [31:0] held_data;
    logic [1:0]  held_resp;
    do @(posedge aclk); while (!rvalid);
    held_data = rdata;
    held_resp = rresp;
    repeat (stall) begin
      @(posedge aclk);
      check_value("rvalid", rvalid, 1'b1);
      check_value("rdata", rdata, held_data);
      check_value("rresp", rresp, held_resp);
    end
    rready <= 1'b1;
    @(posedge aclk);
    check_value("rvalid", rvalid, 1'b1);
    rready <= 1'b0;
    check_value("rdata", held_data, exp_data);
    check_value("rresp", held_resp, exp_resp);
    // valid drops once the single R response is taken
    @(posedge aclk);
    check_value("rvalid", rvalid, 1'b0);
  endtask

  // order 0 sends AW first, 1 sends W first, 2 sends both together
  task automatic run_write(input txn_t t, input logic [1:0] exp_resp);
    logic aw_done;
    logic w_done;
    aw_done = 1'b0;
    w_done  = 1'b0;
    valid_gap();
    if (t.order != 2'd1) begin
      awaddr  <= t.addr;
      awvalid <= 1'b1;
    end
    if (t.order != 2'd0) begin
      wdata  <= t.wdata;
      wstrb  <= t.strb;
      wvalid <= 1'b1;
    end
    while (!(aw_done && w_done)) begin
      @(posedge aclk);
      if (awvalid && awready) begin
        aw_done = 1'b1;
        awvalid <= 1'b0;
        if (t.order == 2'd0) begin
          wdata  <= t.wdata;
          wstrb  <= t.strb;
          wvalid <= 1'b1;
        end
      end
      if (wvalid && wready) begin
        w_done = 1'b1;
        wvalid <= 1'b0;
        if (t.order == 2'd1) begin
          awaddr  <= t.addr;
          awvalid <= 1'b1;
        end
      end
    end
    take_b(t.stall, exp_resp);
  endtask

  task automatic run_read(input txn_t t, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    valid_gap();
    araddr  <= t.addr;
    arvalid <= 1'b1;
    do @(posedge aclk); while (!arready);
    arvalid <= 1'b0;
    take_r(t.stall, exp_data, exp_resp);
  endtask

  initial begin
    logic        in_range;
    logic [1:0]  exp_resp;
    logic [31:0] exp_data;
    int          idx;
    areset  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    load_stimulus();
    cycle_limit = 64 * txn_q.size() + 100;
    repeat (8) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    check_value("rvalid", rvalid, 1'b0);
    check_value("bvalid", bvalid, 1'b0);
    @(posedge aclk);
    check_value("arready", arready, 1'b1);
    check_value("awready", awready, 1'b1);
    check_value("wready", wready, 1'b1);
    foreach (txn_q[i]) begin
      in_range = (txn_q[i].addr >> 2) < mem_depth_words;
      idx      = (txn_q[i].addr >> 2) % mem_depth_words;
      exp_resp = in_range ? 2'd0 : 2'd2;
      check_value("file response", txn_q[i].exp_resp, exp_resp);
      if (txn_q[i].is_write) begin
        run_write(txn_q[i], exp_resp);
        if (in_range) shadow[idx] = merge_bytes(shadow[idx], txn_q[i].wdata, txn_q[i].strb);
      end else begin
        exp_data = in_range ? shadow[idx] : 32'h0;
        check_value("file read data", txn_q[i].exp_rdata, exp_data);
        run_read(txn_q[i], exp_data, exp_resp);
      end
    end
    repeat (4) @(posedge aclk);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* test/axi_sram_properties.sv */
`timescale 1ns/1ps

module axi_sram_properties
  import axi_sram_pkg::*;
(
  input logic                  aclk,
  input logic                  areset,
  input logic                  rvalid,
  input logic                  rready,
  input logic [data_width-1:0] rdata,
  input axi_resp_e             rresp,
  input logic                  bvalid,
  input logic                  bready,
  input axi_resp_e             bresp,
  input logic                  rd_rsp_valid
);

  int unsigned error_count = 0;

  r_hold: assert property (@(posedge aclk) disable iff (areset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $error("R channel dropped or changed before its transfer");
      error_count = error_count + 1;
    end

  b_hold: assert property (@(posedge aclk) disable iff (areset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("B channel dropped or changed before its transfer");
      error_count = error_count + 1;
    end

  quiet_after_reset: assert property (@(posedge aclk) $fell(areset) |-> !rvalid && !bvalid)
    else begin
      $error("response valid in the first cycle after reset");
      error_count = error_count + 1;
    end

  // read credit keeps a second read out of result
  single_read: assert property (@(posedge aclk) disable iff (areset) rvalid |-> !rd_rsp_valid)
    else begin
      $error("second read response arrived before the R transfer");
      error_count = error_count + 1;
    end

  bresp_legal: assert property (@(posedge aclk) disable iff (areset)
    bvalid |-> (bresp == resp_okay) || (bresp == resp_slverr))
    else begin
      $error("bresp holds an unsupported code");
      error_count = error_count + 1;
    end

endmodule

bind axi_sram_top axi_sram_properties u_props (
  .aclk         (aclk),
  .areset       (areset),
  .rvalid       (rvalid),
  .rready       (rready),
  .rdata        (rdata),
  .rresp        (rresp),
  .bvalid       (bvalid),
  .bready       (bready),
  .bresp        (bresp),
  .rd_rsp_valid (rd_rsp.valid)
);

/* hw/axi_sram_top.sv */
`timescale 1ns/1ps

module axi_sram_top
  import axi_sram_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [data_width-1:0] rdata,
  output axi_resp_e             rresp,
  output logic                  rvalid,
  input  logic                  rready,
  input  logic [addr_width-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [data_width-1:0] wdata,
  input  logic [strb_width-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic                  bvalid,
  output axi_resp_e             bresp,
  input  logic                  bready
);

  mem_req_t req;
  mem_rsp_t rd_rsp;
  mem_rsp_t wr_rsp;
  logic     rd_credit_ret;
  logic     wr_credit_ret;

  axi_req_decode u_decode (
    .aclk          (aclk),
    .areset        (areset),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .rd_credit_ret (rd_credit_ret),
    .wr_credit_ret (wr_credit_ret),
    .req           (req)
  );

  sram_array_exec u_exec (
    .aclk   (aclk),
    .areset (areset),
    .req    (req),
    .rd_rsp (rd_rsp),
    .wr_rsp (wr_rsp)
  );

  axi_resp_result u_result (
    .aclk          (aclk),
    .areset        (areset),
    .rd_rsp        (rd_rsp),
    .wr_rsp        (wr_rsp),
    .rready        (rready),
    .bready        (bready),
    .rvalid        (rvalid),
    .bvalid        (bvalid),
    .rdata         (rdata),
    .rresp         (rresp),
    .bresp         (bresp),
    .rd_credit_ret (rd_credit_ret),
    .wr_credit_ret (wr_credit_ret)
  );

endmodule

/* hw/axi_resp_result.sv */
`timescale 1ns/1ps

module axi_resp_result
  import axi_sram_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  mem_rsp_t              rd_rsp,
  input  mem_rsp_t              wr_rsp,
  input  logic                  rready,
  input  logic                  bready,
  output logic                  rvalid,
  output logic                  bvalid,
  output logic [data_width-1:0] rdata,
  output axi_resp_e             rresp,
  output axi_resp_e             bresp,
  output logic                  rd_credit_ret,
  output logic                  wr_credit_ret
);

  logic rd_load;
  logic wr_load;
  logic r_done;
  logic b_done;

  // credits guarantee the register is free when a response lands
  assign rd_load = rd_rsp.valid & (rd_rsp.op == op_read);
  assign wr_load = wr_rsp.valid & (wr_rsp.op == op_write);

  assign r_done = rvalid & rready;
  assign b_done = bvalid & bready;

  always_ff @(posedge aclk) begin
    if (areset) begin
      rvalid <= 1'b0;
    end else if (rd_load) begin
      rvalid <= 1'b1;
    end else if (r_done) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      bvalid <= 1'b0;
    end else if (wr_load) begin
      bvalid <= 1'b1;
    end else if (b_done) begin
      bvalid <= 1'b0;
    end
  end

  // payload only changes on load, so it holds under back-pressure
  always_ff @(posedge aclk) begin
    if (rd_load) begin
      rdata <= rd_rsp.rdata;
      rresp <= rd_rsp.resp;
    end
    if (wr_load) begin
      bresp <= wr_rsp.resp;
    end
  end

  // one credit back per completed transfer
  assign rd_credit_ret = r_done;
  assign wr_credit_ret = b_done;

endmodule

/* hw/sram_array_exec.sv */
`timescale 1ns/1ps

module sram_array_exec
  import axi_sram_pkg::*;
(
  input  logic     aclk,
  input  logic     areset,
  input  mem_req_t req,
  output mem_rsp_t rd_rsp,
  output mem_rsp_t wr_rsp
);

  logic [data_width-1:0]     mem [mem_depth_words];
  logic [mem_addr_width-1:0] word_idx;
  logic                      in_range;
  logic                      do_read;
  logic                      do_write;
  mem_rsp_t                  rd_next;
  mem_rsp_t                  rd_pipe [sram_read_latency];

  assign word_idx = req.addr[mem_addr_width+1:2];
  // anything above the word index must be zero
  assign in_range = (req.addr[addr_width-1:mem_addr_width+2] == '0);
  assign do_read  = req.valid & (req.op == op_read);
  assign do_write = req.valid & (req.op == op_write);

  // out of range writes are dropped
  always_ff @(posedge aclk) begin
    if (do_write && in_range) begin
      for (int i = 0; i < strb_width; i++) begin
        if (req.wstrb[i]) begin
          mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    rd_next.valid = do_read;
    rd_next.op    = op_read;
    rd_next.rdata = in_range ? mem[word_idx] : '0;
    rd_next.resp  = in_range ? resp_okay : resp_slverr;
  end

  // read pipeline
  always_ff @(posedge aclk) begin
    if (areset) begin
      for (int i = 0; i < sram_read_latency; i++) begin
        rd_pipe[i].valid <= 1'b0;
      end
    end else begin
      rd_pipe[0].valid <= rd_next.valid;
      for (int i = 1; i < sram_read_latency; i++) begin
        rd_pipe[i].valid <= rd_pipe[i-1].valid;
      end
    end
  end

  always_ff @(posedge aclk) begin
    rd_pipe[0].op    <= rd_next.op;
    rd_pipe[0].rdata <= rd_next.rdata;
    rd_pipe[0].resp  <= rd_next.resp;
    for (int i = 1; i < sram_read_latency; i++) begin
      rd_pipe[i].op    <= rd_pipe[i-1].op;
      rd_pipe[i].rdata <= rd_pipe[i-1].rdata;
      rd_pipe[i].resp  <= rd_pipe[i-1].resp;
    end
  end

  assign rd_rsp = rd_pipe[sram_read_latency-1];

  // write response one cycle after the write
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_rsp.valid <= 1'b0;
    end else begin
      wr_rsp.valid <= do_write;
    end
  end

  always_ff @(posedge aclk) begin
    wr_rsp.op    <= op_write;
    wr_rsp.rdata <= '0;
    wr_rsp.resp  <= in_range ? resp_okay : resp_slverr;
  end

endmodule

/* hw/axi_req_decode.sv */
`timescale 1ns/1ps

module axi_req_decode
  import axi_sram_pkg::*;
(
  input  logic                  aclk,
  input  logic                  areset,
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [addr_width-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [data_width-1:0] wdata,
  input  logic [strb_width-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic                  rd_credit_ret,
  input  logic                  wr_credit_ret,
  output mem_req_t              req
);

  logic                  ready_en;
  logic                  rd_pending;
  logic [addr_width-1:0] rd_addr_q;
  decode_state_e         wr_state;
  logic [addr_width-1:0] wr_addr_q;
  logic [data_width-1:0] wr_data_q;
  logic [strb_width-1:0] wr_strb_q;
  logic                  rd_credit;
  logic                  wr_credit;
  logic                  ar_hs;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  issue_rd;
  logic                  issue_wr;

  // readies held low until the cycle after reset
  always_ff @(posedge aclk) begin
    if (areset) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  assign arready = ready_en & ~rd_pending;
  assign awready = ready_en & ((wr_state == wr_empty) | (wr_state == wr_have_data));
  assign wready  = ready_en & ((wr_state == wr_empty) | (wr_state == wr_have_addr));

  assign ar_hs = arvalid & arready;
  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  // write wins when both are ready
  assign issue_wr = (wr_state == wr_ready) & wr_credit;
  assign issue_rd = rd_pending & rd_credit & ~issue_wr;

  always_ff @(posedge aclk) begin
    if (areset) begin
      rd_pending <= 1'b0;
      wr_state   <= wr_empty;
      rd_credit  <= 1'b1;
      wr_credit  <= 1'b1;
    end else begin
      if (ar_hs) begin
        rd_pending <= 1'b1;
      end else if (issue_rd) begin
        rd_pending <= 1'b0;
      end
      case (wr_state)
        wr_empty: begin
          if (aw_hs && w_hs) begin
            wr_state <= wr_ready;
          end else if (aw_hs) begin
            wr_state <= wr_have_addr;
          end else if (w_hs) begin
            wr_state <= wr_have_data;
          end
        end
        wr_have_addr: if (w_hs) wr_state <= wr_ready;
        wr_have_data: if (aw_hs) wr_state <= wr_ready;
        default:      if (issue_wr) wr_state <= wr_empty;
      endcase
      // a credit is only returned while it is in use
      if (rd_credit_ret) begin
        rd_credit <= 1'b1;
      end else if (issue_rd) begin
        rd_credit <= 1'b0;
      end
      if (wr_credit_ret) begin
        wr_credit <= 1'b1;
      end else if (issue_wr) begin
        wr_credit <= 1'b0;
      end
    end
  end

  // captured beats
  always_ff @(posedge aclk) begin
    if (ar_hs) rd_addr_q <= araddr;
    if (aw_hs) wr_addr_q <= awaddr;
    if (w_hs) begin
      wr_data_q <= wdata;
      wr_strb_q <= wstrb;
    end
  end

  always_comb begin
    req.valid = issue_wr | issue_rd;
    req.op    = issue_wr ? op_write : op_read;
    req.addr  = issue_wr ? wr_addr_q : rd_addr_q;
    req.wdata = wr_data_q;
    req.wstrb = issue_wr ? wr_strb_q : '0;
  end

endmodule

/* hw/axi_sram_pkg.sv */
package axi_sram_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  // memory size in words
  // word index taken from byte address bits 9:2
  localparam int mem_depth_words = 256;
  localparam int mem_addr_width = $clog2(mem_depth_words);

  // cycles from request issue to read data in execute
  localparam int sram_read_latency = 1;

  typedef enum logic [1:0] {
    resp_okay   = 2'd0,
    resp_slverr = 2'd2
  } axi_resp_e;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // write address / data pairing
  typedef enum logic [1:0] {
    wr_empty,
    wr_have_addr,
    wr_have_data,
    wr_ready
  } decode_state_e;

  typedef struct packed {
    logic                  valid;
    mem_op_e               op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic                  valid;
    mem_op_e               op;
    logic [data_width-1:0] rdata;
    axi_resp_e             resp;
  } mem_rsp_t;

endpackage
